/* ckpt_cfg.svh */
`ifndef CKPT_CFG_SVH
`define CKPT_CFG_SVH

// ==================================================
// Checkpoint subsystem sizing
// ==================================================

// Number of reorder-buffer groups tracked by a header each
`define GROUPS 16

// Width of a group index, log2 of the group count
`define GNDX_W 4

// Number of register-map checkpoints in the pool
`define CHKPTS 16

// Width of a checkpoint index, log2 of the checkpoint count
// The free counter is one bit wider so that a full pool fits
`define CNDX_W 4

`endif

/* verilog/rob_pkg.sv */
`default_nettype none

`include "ckpt_cfg.svh"

// ==================================================
// Reorder-buffer group types
// ==================================================

package rob_pkg;

	// Index of one group header in the reorder buffer
	typedef logic [`GNDX_W-1:0] group_ndx_t;

	// One group header, eight bits in all
	// v is set while the group sits in the reorder buffer
	// done is set once every instruction of the group has completed
	// has_branch tells that the group owns a checkpoint
	// chkpt_freed is set once that checkpoint went back to the pool
	// The checkpoint index is kept as a plain vector so that this
	// package stands on its own without the pool types
	typedef struct packed {
		logic v;
		logic done;
		logic has_branch;
		logic chkpt_freed;
		logic [`CNDX_W-1:0] cndx;
	} group_hdr_t;

endpackage

`default_nettype wire

/* verilog/ckpt_pkg.sv */
`default_nettype none

`include "ckpt_cfg.svh"

// ==================================================
// Checkpoint pool types
// ==================================================

package ckpt_pkg;

	// Index of one register-map checkpoint
	typedef logic [`CNDX_W-1:0] chkpt_ndx_t;

	// Group being dispatched and whether it holds a branch
	typedef struct packed {
		logic [`GNDX_W-1:0] gndx;
		logic has_branch;
	} disp_req_t;

	// Checkpoint to return and the group that owned it
	typedef struct packed {
		logic valid;
		chkpt_ndx_t chkpt;
		logic [`GNDX_W-1:0] gndx;
	} free_evt_t;

endpackage

`default_nettype wire

/* verilog/group_header_table.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ckpt_cfg.svh"

// Register array holding one header per reorder-buffer group
module group_header_table
	import rob_pkg::*;
	import ckpt_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	// New group from dispatch
	input wire logic hdr_write,
	input wire disp_req_t disp_req,
	input wire chkpt_ndx_t hdr_cndx,
	// Group completion
	input wire logic done_valid,
	input wire group_ndx_t done_gndx,
	// Group leaves the reorder buffer
	input wire logic retire_valid,
	input wire group_ndx_t retire_gndx,
	// Checkpoint of a group went back to the pool
	input wire logic mark_freed,
	input wire group_ndx_t mark_gndx,
	// Every header, seen by the freer
	output group_hdr_t [`GROUPS-1:0] pgh
);

	// ==================================================
	// Header updates
	// ==================================================

	// Several strobes may hit the same group in one cycle
	// The later statements win, so a fresh dispatch overrides any
	// leftover update aimed at the previous occupant of that slot
	always_ff @(posedge clk) begin
		if (rst) begin
			// Only the flag bits are cleared, the checkpoint index is
			// meaningless until has_branch is set again
			for (int g = 0; g < `GROUPS; g++) begin
				pgh[g].v <= 1'b0;
				pgh[g].done <= 1'b0;
				pgh[g].has_branch <= 1'b0;
				pgh[g].chkpt_freed <= 1'b0;
			end
		end else begin
			// Retire drops the group but keeps has_branch, so a group
			// that never finished still gets its checkpoint back
			if (retire_valid) begin
				pgh[retire_gndx].v <= 1'b0;
			end
			if (done_valid) begin
				pgh[done_gndx].done <= 1'b1;
			end
			if (mark_freed) begin
				pgh[mark_gndx].chkpt_freed <= 1'b1;
			end
			// New header, valid and not yet freed
			if (hdr_write) begin
				pgh[disp_req.gndx].v <= 1'b1;
				pgh[disp_req.gndx].done <= 1'b0;
				pgh[disp_req.gndx].has_branch <= disp_req.has_branch;
				pgh[disp_req.gndx].chkpt_freed <= 1'b0;
				pgh[disp_req.gndx].cndx <= hdr_cndx;
			end
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	// Completion may only be reported for a group that is in flight
	a_done_needs_valid: assert property (@(posedge clk) disable iff (rst)
		done_valid |-> pgh[done_gndx].v)
	else $error("group %0d marked done while invalid", done_gndx);

endmodule

`default_nettype wire

/* verilog/checkpoint_freer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ckpt_cfg.svh"

// Finds groups whose checkpoint can be returned and reports one per cycle
module checkpoint_freer
	import rob_pkg::*;
	import ckpt_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire group_hdr_t [`GROUPS-1:0] pgh,
	output free_evt_t free_evt
);

	logic [`GROUPS-1:0] qual;
	free_evt_t next_evt;

	// A group may give back its checkpoint once all its branches have
	// resolved, which is the case when it is done or already gone
	// The freed flag keeps the same checkpoint from returning twice
	function automatic logic can_free(group_hdr_t h);
		return !h.chkpt_freed && (h.done || !h.v) && h.has_branch;
	endfunction

	// ==================================================
	// Candidate search
	// ==================================================

	always_comb begin
		for (int g = 0; g < `GROUPS; g++) begin
			qual[g] = can_free(pgh[g]);
		end
		// The group reported last cycle still shows as not freed,
		// its mark lands on the same edge that loads the next event
		if (free_evt.valid) begin
			qual[free_evt.gndx] = 1'b0;
		end
	end

	// Highest qualifying index wins
	// Walking upward lets the last hit overwrite the earlier ones
	always_comb begin
		next_evt = '0;
		for (int g = 0; g < `GROUPS; g++) begin
			if (qual[g]) begin
				next_evt.valid = 1'b1;
				next_evt.chkpt = pgh[g].cndx;
				next_evt.gndx = group_ndx_t'(g);
			end
		end
	end

	// Registered event, the payload has no reset value
	always_ff @(posedge clk) begin
		if (rst) begin
			free_evt.valid <= 1'b0;
		end else begin
			free_evt <= next_evt;
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	// Back to back events never name the same group
	a_no_repeat: assert property (@(posedge clk) disable iff (rst)
		free_evt.valid && $past(free_evt.valid) |->
			free_evt.gndx != $past(free_evt.gndx))
	else $error("group %0d reported twice in a row", free_evt.gndx);

endmodule

`default_nettype wire

/* verilog/checkpoint_free_list.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ckpt_cfg.svh"

// Pool of register-map checkpoints kept as a bitmap, one bit per free entry
module checkpoint_free_list
	import ckpt_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	// Take the index offered on alloc_chkpt
	input wire logic alloc_take,
	output chkpt_ndx_t alloc_chkpt,
	// Give an index back
	input wire logic release_valid,
	input wire chkpt_ndx_t release_chkpt,
	output logic [`CNDX_W:0] free_count
);

	// Counter value with every checkpoint in the pool
	localparam logic [`CNDX_W:0] ALL_FREE = `CHKPTS;

	logic [`CHKPTS-1:0] free_map;

	// ==================================================
	// Allocation
	// ==================================================

	// Lowest free index, found by walking down so the smallest hit is
	// the last one written
	// With an empty pool the value is zero and must not be taken
	always_comb begin
		alloc_chkpt = '0;
		for (int c = `CHKPTS - 1; c >= 0; c--) begin
			if (free_map[c]) begin
				alloc_chkpt = chkpt_ndx_t'(c);
			end
		end
	end

	// Taken and released indexes differ in one cycle, since a release
	// always names an entry that is out of the pool
	always_ff @(posedge clk) begin
		if (rst) begin
			free_map <= '1;
		end else begin
			if (alloc_take) begin
				free_map[alloc_chkpt] <= 1'b0;
			end
			if (release_valid) begin
				free_map[release_chkpt] <= 1'b1;
			end
		end
	end

	// Counter moves only when exactly one of the two strobes is up
	always_ff @(posedge clk) begin
		if (rst) begin
			free_count <= ALL_FREE;
		end else if (alloc_take && !release_valid) begin
			free_count <= free_count - 1'b1;
		end else if (release_valid && !alloc_take) begin
			free_count <= free_count + 1'b1;
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	// A checkpoint still in the pool is never handed back again
	a_no_double_release: assert property (@(posedge clk) disable iff (rst)
		release_valid |-> !free_map[release_chkpt])
	else $error("checkpoint %0d released while free", release_chkpt);

	// The counter tracks the bitmap across every update
	a_count_matches: assert property (@(posedge clk) disable iff (rst)
		int'(free_count) == $countones(free_map))
	else $error("free_count %0d disagrees with the bitmap", free_count);

endmodule

`default_nettype wire

/* verilog/checkpoint_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ckpt_cfg.svh"

// Dispatch acceptance, checkpoint allocation and free routing
module checkpoint_ctrl
	import rob_pkg::*;
	import ckpt_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic disp_valid,
	input wire disp_req_t disp_req,
	output logic disp_ready,
	input wire logic [`CNDX_W:0] free_count,
	output logic alloc_take,
	output logic hdr_write,
	output chkpt_ndx_t hdr_cndx,
	input wire chkpt_ndx_t alloc_chkpt,
	input wire free_evt_t free_in,
	output logic mark_freed,
	output group_ndx_t mark_gndx,
	output logic release_valid,
	output chkpt_ndx_t release_chkpt
);

	logic accept;
	// Groups that currently own a checkpoint, per the dispatches seen here
	logic [`GROUPS-1:0] branch_owned;

	// ==================================================
	// Dispatch side
	// ==================================================

	// Only a branch group needs a checkpoint, so only it can stall
	assign disp_ready = !(disp_req.has_branch && (free_count == '0));
	assign accept = disp_valid && disp_ready;

	// Header and bitmap both update at the edge ending the accept cycle
	assign hdr_write = accept;
	assign alloc_take = accept && disp_req.has_branch;
	// A group without a branch carries no meaningful index
	assign hdr_cndx = disp_req.has_branch ? alloc_chkpt : '0;

	// ==================================================
	// Free side
	// ==================================================

	// The freer's event is already registered, so the mark and the
	// release both take effect on the edge right after it
	assign mark_freed = free_in.valid;
	assign mark_gndx = free_in.gndx;
	assign release_valid = free_in.valid;
	assign release_chkpt = free_in.chkpt;

	// Ownership follows dispatch and release, a new dispatch of the same
	// group overrides a release in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			branch_owned <= '0;
		end else begin
			if (release_valid) begin
				branch_owned[free_in.gndx] <= 1'b0;
			end
			if (accept) begin
				branch_owned[disp_req.gndx] <= disp_req.has_branch;
			end
		end
	end

	// An empty pool never hands out a checkpoint
	a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst)
		alloc_take |-> free_count != '0)
	else $error("allocation with an empty pool");

	// A release always belongs to a group dispatched with a branch
	a_release_owned: assert property (@(posedge clk) disable iff (rst)
		release_valid |-> branch_owned[free_in.gndx])
	else $error("release for group %0d without a branch", free_in.gndx);

endmodule

`default_nettype wire

/* verilog/checkpoint_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ckpt_cfg.svh"

// Checkpoint management subsystem, control with its three datapath blocks
module checkpoint_unit_top
	import rob_pkg::*;
	import ckpt_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic disp_valid,
	input wire disp_req_t disp_req,
	output logic disp_ready,
	input wire logic done_valid,
	input wire group_ndx_t done_gndx,
	input wire logic retire_valid,
	input wire group_ndx_t retire_gndx,
	output chkpt_ndx_t alloc_chkpt,
	output free_evt_t free_evt,
	output logic [`CNDX_W:0] free_count
);

	// ==================================================
	// Internal nets
	// ==================================================

	group_hdr_t [`GROUPS-1:0] pgh;
	logic alloc_take;
	logic hdr_write;
	chkpt_ndx_t hdr_cndx;
	logic mark_freed;
	group_ndx_t mark_gndx;
	logic release_valid;
	chkpt_ndx_t release_chkpt;

	// Decides acceptance and routes the free events
	checkpoint_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_req(disp_req),
		.disp_ready(disp_ready),
		.free_count(free_count),
		.alloc_take(alloc_take),
		.hdr_write(hdr_write),
		.hdr_cndx(hdr_cndx),
		.alloc_chkpt(alloc_chkpt),
		.free_in(free_evt),
		.mark_freed(mark_freed),
		.mark_gndx(mark_gndx),
		.release_valid(release_valid),
		.release_chkpt(release_chkpt)
	);

	// Group headers of the reorder buffer
	group_header_table u_hdr (
		.clk(clk),
		.rst(rst),
		.hdr_write(hdr_write),
		.disp_req(disp_req),
		.hdr_cndx(hdr_cndx),
		.done_valid(done_valid),
		.done_gndx(done_gndx),
		.retire_valid(retire_valid),
		.retire_gndx(retire_gndx),
		.mark_freed(mark_freed),
		.mark_gndx(mark_gndx),
		.pgh(pgh)
	);

	// Scans the headers for checkpoints ready to return
	checkpoint_freer u_freer (
		.clk(clk),
		.rst(rst),
		.pgh(pgh),
		.free_evt(free_evt)
	);

	// Checkpoint pool
	checkpoint_free_list u_pool (
		.clk(clk),
		.rst(rst),
		.alloc_take(alloc_take),
		.alloc_chkpt(alloc_chkpt),
		.release_valid(release_valid),
		.release_chkpt(release_chkpt),
		.free_count(free_count)
	);

endmodule

`default_nettype wire

/* verification/checkpoint_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ckpt_cfg.svh"

module checkpoint_unit_tb
	import rob_pkg::*;
	import ckpt_pkg::*;
();

	// The directed phases take about 60 cycles, the random phase 400 and the drain
	// at most a few dozen more, so 2000 leaves a wide margin
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int RANDOM_STEPS = 400;

	logic clk;
	logic rst;
	logic disp_valid;
	disp_req_t disp_req;
	logic disp_ready;
	logic done_valid;
	group_ndx_t done_gndx;
	logic retire_valid;
	group_ndx_t retire_gndx;
	chkpt_ndx_t alloc_chkpt;
	free_evt_t free_evt;
	logic [`CNDX_W:0] free_count;

	// Reference pool and per-group record
	logic [`CHKPTS-1:0] m_free;
	logic [`GROUPS-1:0] m_valid;
	logic [`GROUPS-1:0] m_done;
	logic [`GROUPS-1:0] m_branch;
	logic [`GROUPS-1:0] m_freed;
	chkpt_ndx_t m_cndx [`GROUPS];
	// Set once any group was done or retired, before that no free can happen
	logic release_seen;
	// Acceptance at the last rising edge, read by the stimulus at the falling edge
	logic accepted_q;
	logic accept;
	integer seed = 32'h2238_67b7;
	int cycles = 0;

	checkpoint_unit_top dut_i (
		.clk(clk),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_req(disp_req),
		.disp_ready(disp_ready),
		.done_valid(done_valid),
		.done_gndx(done_gndx),
		.retire_valid(retire_valid),
		.retire_gndx(retire_gndx),
		.alloc_chkpt(alloc_chkpt),
		.free_evt(free_evt),
		.free_count(free_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	assign accept = disp_valid && disp_ready;

	// ==================================================
	// Reference model helpers
	// ==================================================

	// The pool hands out its smallest free index
	function automatic chkpt_ndx_t lowest_free(input logic [`CHKPTS-1:0] map);
		for (int c = 0; c < `CHKPTS; c++) begin
			if (map[c]) begin
				return chkpt_ndx_t'(c);
			end
		end
		return '0;
	endfunction

	function automatic logic [`CNDX_W:0] count_free(input logic [`CHKPTS-1:0] map);
		logic [`CNDX_W:0] n;
		n = '0;
		for (int c = 0; c < `CHKPTS; c++) begin
			n = n + {{`CNDX_W{1'b0}}, map[c]};
		end
		return n;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Model follows the accept and free_evt cycles seen at each rising edge
	always @(posedge clk) begin
		if (rst) begin
			m_free <= '1;
			m_valid <= '0;
			m_done <= '0;
			m_branch <= '0;
			m_freed <= '0;
			release_seen <= 1'b0;
			accepted_q <= 1'b0;
		end else begin
			accepted_q <= accept;
			if (done_valid || retire_valid) begin
				release_seen <= 1'b1;
			end
			// The returned checkpoint is the one recorded for the group
			if (free_evt.valid) begin
				m_freed[free_evt.gndx] <= 1'b1;
				m_free[m_cndx[free_evt.gndx]] <= 1'b1;
			end
			if (retire_valid) begin
				m_valid[retire_gndx] <= 1'b0;
			end
			if (done_valid) begin
				m_done[done_gndx] <= 1'b1;
			end
			if (accept) begin
				m_valid[disp_req.gndx] <= 1'b1;
				m_done[disp_req.gndx] <= 1'b0;
				m_branch[disp_req.gndx] <= disp_req.has_branch;
				m_freed[disp_req.gndx] <= 1'b0;
				if (disp_req.has_branch) begin
					m_cndx[disp_req.gndx] <= lowest_free(m_free);
					m_free[lowest_free(m_free)] <= 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_on_error("Timeout, the test did not finish within the cycle limit");
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	a_free_count: assert property (@(posedge clk) disable iff (rst)
		free_count == count_free(m_free))
	else stop_on_error($sformatf("** Error free_count: got %h expected %h",
		$sampled(free_count), count_free($sampled(m_free))));

	// Ready drops only for a branch request with nothing left in the pool
	a_disp_ready: assert property (@(posedge clk) disable iff (rst)
		disp_ready == !(disp_req.has_branch && count_free(m_free) == '0))
	else stop_on_error($sformatf("** Error disp_ready: got %h expected %h",
		$sampled(disp_ready),
		!($sampled(disp_req.has_branch) && count_free($sampled(m_free)) == '0)));

	a_alloc_chkpt: assert property (@(posedge clk) disable iff (rst)
		accept && disp_req.has_branch |-> alloc_chkpt == lowest_free(m_free))
	else stop_on_error($sformatf("** Error alloc_chkpt: got %h expected %h",
		$sampled(alloc_chkpt), lowest_free($sampled(m_free))));

	// Nothing can be freed before a group was done or retired
	a_quiet_start: assert property (@(posedge clk) disable iff (rst)
		!release_seen |-> !free_evt.valid)
	else stop_on_error("A free event appeared before any group was done or retired");

	a_free_owner: assert property (@(posedge clk) disable iff (rst)
		free_evt.valid |-> m_branch[free_evt.gndx] && !m_freed[free_evt.gndx] &&
			(m_done[free_evt.gndx] || !m_valid[free_evt.gndx]))
	else stop_on_error($sformatf("Free event for group %0d, which is not waiting for a free",
		$sampled(free_evt.gndx)));

	a_free_chkpt: assert property (@(posedge clk) disable iff (rst)
		free_evt.valid |-> free_evt.chkpt == m_cndx[free_evt.gndx])
	else stop_on_error($sformatf("** Error free_evt.chkpt: got %h expected %h",
		$sampled(free_evt.chkpt), m_cndx[$sampled(free_evt.gndx)]));

	// ==================================================
	// Stimulus tasks, each called and returning at a falling edge
	// ==================================================

	// Holds the request until a rising edge accepts it
	task automatic dispatch_group(input group_ndx_t g, input logic br);
		disp_valid = 1'b1;
		disp_req.gndx = g;
		disp_req.has_branch = br;
		@(negedge clk);
		while (!accepted_q) begin
			@(negedge clk);
		end
		disp_valid = 1'b0;
	endtask

	task automatic mark_done(input group_ndx_t g);
		done_valid = 1'b1;
		done_gndx = g;
		@(negedge clk);
		done_valid = 1'b0;
	endtask

	task automatic retire_group(input group_ndx_t g);
		retire_valid = 1'b1;
		retire_gndx = g;
		@(negedge clk);
		retire_valid = 1'b0;
	endtask

	task automatic pick_group(output group_ndx_t g);
		g = group_ndx_t'($unsigned($random(seed)) % `GROUPS);
	endtask

	initial begin
		group_ndx_t g;
		logic br;
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_req = '0;
		done_valid = 1'b0;
		done_gndx = '0;
		retire_valid = 1'b0;
		retire_gndx = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (5) @(negedge clk);

		// Fill the pool with one branch group per slot
		for (int i = 0; i < `GROUPS; i++) begin
			dispatch_group(group_ndx_t'(i), 1'b1);
		end

		// Full pool, a branch request stalls and a plain one does not
		disp_req = '{gndx: group_ndx_t'(5), has_branch: 1'b1};
		@(negedge clk);
		if (free_count != '0) begin
			stop_on_error("Pool is not empty after sixteen branch dispatches");
		end
		disp_req.has_branch = 1'b0;
		@(negedge clk);
		disp_req.has_branch = 1'b1;
		mark_done(group_ndx_t'(5));
		while (!disp_ready) begin
			@(negedge clk);
		end
		retire_group(group_ndx_t'(5));
		dispatch_group(group_ndx_t'(5), 1'b1);

		// A group retired without finishing still returns its checkpoint
		retire_group(group_ndx_t'(7));
		while (!m_freed[7]) begin
			@(negedge clk);
		end
		dispatch_group(group_ndx_t'(7), 1'b0);

		// ==================================================
		// Random mix of dispatch, done and retire
		// ==================================================

		for (int i = 0; i < RANDOM_STEPS; i++) begin
			pick_group(g);
			br = 1'($random(seed) & 1);
			// A slot is reused only once its old checkpoint is back
			if (!m_valid[g] && (!m_branch[g] || m_freed[g]) &&
					(!br || count_free(m_free) != '0)) begin
				disp_valid = 1'b1;
				disp_req.gndx = g;
				disp_req.has_branch = br;
			end
			pick_group(g);
			if (m_valid[g] && !m_done[g] && ($unsigned($random(seed)) % 3 == 0)) begin
				done_valid = 1'b1;
				done_gndx = g;
			end
			pick_group(g);
			if (m_valid[g] && ($unsigned($random(seed)) % 4 == 0)) begin
				retire_valid = 1'b1;
				retire_gndx = g;
			end
			@(negedge clk);
			disp_valid = 1'b0;
			done_valid = 1'b0;
			retire_valid = 1'b0;
		end

		// Finish every group still in flight and let the pool refill
		for (int i = 0; i < `GROUPS; i++) begin
			if (m_valid[i] && !m_done[i]) begin
				mark_done(group_ndx_t'(i));
			end
		end
		while (free_count != `CHKPTS) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);

		if (free_count == `CHKPTS && m_free == '1) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_on_error($sformatf("** Error free_count: got %h expected %h",
				free_count, `CHKPTS));
		end
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
verilog/rob_pkg.sv
verilog/ckpt_pkg.sv
verilog/group_header_table.sv
verilog/checkpoint_freer.sv
verilog/checkpoint_free_list.sv
verilog/checkpoint_ctrl.sv
verilog/checkpoint_unit_top.sv
verification/checkpoint_unit_tb.sv

/* Makefile */
# Verilator flow for the checkpoint unit
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= checkpoint_unit_tb
RTL_TOP   ?= checkpoint_unit_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

# The run counts as passed only when the pass message shows up in its output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
